// ==== vga_pkg.sv ====
package vga_pkg;

  // ------------------------------
  // 640x480 mode
  // ------------------------------
  localparam logic [11:0] h_disp_start = 12'd47;
  localparam logic [11:0] h_disp_width = 12'd640;
  localparam logic [11:0] h_sync_width = 12'd96;
  localparam logic [11:0] h_total      = 12'd799;  // last count of a line
  localparam logic [11:0] v_disp_start = 12'd31;
  localparam logic [11:0] v_disp_width = 12'd480;
  localparam logic [11:0] v_sync_width = 12'd2;
  localparam logic [11:0] v_total      = 12'd524;

  localparam logic [1:0]  sync_polarity = 2'b00;  // [1] hsync, [0] vsync, 0 = active low

  // ------------------------------
  // frame buffer and memory side
  // ------------------------------
  localparam int word_bytes = 16;
  localparam int page_bytes = 4096;
  localparam int word_bits  = 128;
  localparam int fifo_depth = 16;

  localparam logic [31:0] disp_base  = 32'h0;
  localparam logic [12:0] line_pitch = 13'd80;
  localparam logic [7:0]  line_words = 8'(line_pitch / word_bytes);

  localparam logic [2:0]  ar_size_16b   = 3'b100;
  localparam logic [1:0]  ar_burst_incr = 2'b01;

  typedef struct packed {
    logic        valid;
    logic [31:0] addr;   // byte address of first word
  } line_req_t;

  typedef struct packed {
    logic [3:0]  id;
    logic [26:0] addr;
    logic [7:0]  len;
    logic [2:0]  size;
    logic [1:0]  burst;
    logic        lock;
  } mem_ar_t;

  typedef struct packed {
    logic [3:0]           id;
    logic [word_bits-1:0] data;
    logic [1:0]           resp;
    logic                 last;
  } mem_r_t;

  typedef struct packed {
    logic hsync;
    logic hblank;
    logic vsync;
    logic vblank;
  } sync_t;

  typedef struct packed {
    logic [7:0] r;
    logic [7:0] g;
    logic [7:0] b;
  } pix_t;

  // syncs inactive, both blanks set
  localparam sync_t sync_reset = '{hsync: ~sync_polarity[1], hblank: 1'b1,
                                   vsync: ~sync_polarity[0], vblank: 1'b1};

endpackage

// ==== vga_timing.sv ====
`timescale 1ns/1ps

module vga_timing
  import vga_pkg::*;
(
  input  logic      vga_clk,
  input  logic      mem_reset,
  output sync_t     sync_pre,
  output logic      de_pre,
  output line_req_t line_req
);

  logic [11:0] h_cnt;
  logic [11:0] v_cnt;
  logic [11:0] v_next;
  logic        h_wrap;
  logic        h_active;
  logic        v_active;
  logic        next_active;
  logic [31:0] line_addr;   // address of the next line to fetch
  logic        req_valid;
  logic [31:0] req_addr;

  assign h_wrap = (h_cnt == h_total);
  assign v_next = (v_cnt == v_total) ? 12'd0 : v_cnt + 12'd1;

  assign h_active    = (h_cnt > h_disp_start) && (h_cnt <= h_disp_start + h_disp_width);
  assign v_active    = (v_cnt > v_disp_start) && (v_cnt <= v_disp_start + v_disp_width);
  assign next_active = (v_next > v_disp_start) && (v_next <= v_disp_start + v_disp_width);

  // ------------------------------
  // counters
  // ------------------------------
  always_ff @(posedge vga_clk) begin
    if (mem_reset) begin
      h_cnt <= '0;
      v_cnt <= '0;
    end else if (h_wrap) begin
      h_cnt <= '0;
      v_cnt <= v_next;
    end else begin
      h_cnt <= h_cnt + 12'd1;
    end
  end

  // ------------------------------
  // line requests
  // ------------------------------
  always_ff @(posedge vga_clk) begin
    if (mem_reset) begin
      req_valid <= 1'b0;
      line_addr <= disp_base;
    end else begin
      req_valid <= h_wrap && next_active;
      if (h_wrap && next_active) begin
        if (v_next == v_disp_start + 12'd1) begin
          line_addr <= disp_base + 32'(line_pitch);  // first line of the frame
        end else begin
          line_addr <= line_addr + 32'(line_pitch);
        end
      end
    end
  end

  always_ff @(posedge vga_clk) begin
    if (h_wrap && next_active) begin
      req_addr <= (v_next == v_disp_start + 12'd1) ? disp_base : line_addr;
    end
  end

  assign line_req = '{valid: req_valid, addr: req_addr};

  // sync and blank, one cycle behind the count
  always_ff @(posedge vga_clk) begin
    if (mem_reset) begin
      sync_pre <= sync_reset;
      de_pre   <= 1'b0;
    end else begin
      sync_pre.hsync  <= sync_polarity[1] ^ ~(h_cnt > h_total - h_sync_width);
      sync_pre.hblank <= ~h_active;
      sync_pre.vsync  <= sync_polarity[0] ^ ~(v_cnt > v_total - v_sync_width);
      sync_pre.vblank <= ~v_active;
      de_pre          <= h_active && v_active;
    end
  end

endmodule

// ==== line_fetch.sv ====
`timescale 1ns/1ps

module line_fetch
  import vga_pkg::*;
(
  input  logic                 vga_clk,
  input  logic                 mem_reset,
  input  line_req_t            line_req,
  output mem_ar_t              mem_ar,
  output logic                 mem_arvalid,
  input  logic                 mem_arready,
  input  mem_r_t               mem_r,
  input  logic                 mem_rvalid,
  output logic                 mem_rready,
  output logic                 fifo_flush,
  output logic                 fifo_push,
  output logic [word_bits-1:0] fifo_din
);

  typedef enum logic [2:0] {
    st_idle,
    st_flush,
    st_first,
    st_wait,
    st_second
  } fetch_state_t;

  fetch_state_t state;

  logic [31:0] req_addr;
  logic [31:0] next_addr;
  logic [7:0]  rest_words;
  logic [12:0] room_bytes;
  logic [8:0]  room_words;
  logic        split;
  logic [7:0]  first_len;

  function automatic mem_ar_t burst_ar(input logic [31:0] addr, input logic [7:0] words);
    mem_ar_t ar;
    ar.id    = '0;
    ar.addr  = addr[26:0];
    ar.len   = words - 8'd1;
    ar.size  = ar_size_16b;
    ar.burst = ar_burst_incr;
    ar.lock  = 1'b0;
    return ar;
  endfunction

  // words left before the next 4k boundary
  assign room_bytes = 13'(page_bytes) - {1'b0, req_addr[11:0]};
  assign room_words = room_bytes[12:4];
  assign split      = room_words < {1'b0, line_words};
  assign first_len  = split ? room_words[7:0] : line_words;

  // ------------------------------
  // address channel FSM
  // ------------------------------
  always_ff @(posedge vga_clk) begin
    if (mem_reset) begin
      state       <= st_idle;
      mem_arvalid <= 1'b0;
    end else begin
      case (state)
        st_idle: begin
          if (line_req.valid) state <= st_flush;
        end
        st_flush: begin
          mem_arvalid <= 1'b1;
          state       <= st_first;
        end
        st_first: begin
          if (mem_arready) begin
            mem_arvalid <= 1'b0;
            state       <= (rest_words != 8'd0) ? st_wait : st_idle;
          end
        end
        st_wait: begin
          mem_arvalid <= 1'b1;  // second half, from the page start
          state       <= st_second;
        end
        st_second: begin
          if (mem_arready) begin
            mem_arvalid <= 1'b0;
            state       <= st_idle;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  always_ff @(posedge vga_clk) begin
    if (state == st_idle && line_req.valid) req_addr <= line_req.addr;
    if (state == st_flush) begin
      mem_ar     <= burst_ar(req_addr, first_len);
      next_addr  <= req_addr + 32'(room_words) * 32'(word_bytes);
      rest_words <= line_words - first_len;
    end
    if (state == st_wait) mem_ar <= burst_ar(next_addr, rest_words);
  end

  assign fifo_flush = (state == st_flush);

  // read data goes straight to the FIFO
  assign mem_rready = 1'b1;
  assign fifo_push  = mem_rvalid;
  assign fifo_din   = mem_r.data;

  // ------------------------------
  // checks
  // ------------------------------
  ar_hold: assert property (@(posedge vga_clk) disable iff (mem_reset)
    mem_arvalid && !mem_arready |=> mem_arvalid && $stable(mem_ar));

  ar_in_page: assert property (@(posedge vga_clk) disable iff (mem_reset)
    mem_arvalid |->
      int'(mem_ar.addr[11:0]) + (int'(mem_ar.len) + 1) * word_bytes <= page_bytes);

  req_when_idle: assert property (@(posedge vga_clk) disable iff (mem_reset)
    line_req.valid |-> state == st_idle);

endmodule

// ==== pixel_fifo.sv ====
`timescale 1ns/1ps

module pixel_fifo
  import vga_pkg::*;
(
  input  logic                 vga_clk,
  input  logic                 mem_reset,
  input  logic                 flush,
  input  logic                 push,
  input  logic [word_bits-1:0] din,
  input  logic                 pop,
  output logic [word_bits-1:0] dout,
  output logic                 empty
);

  logic [word_bits-1:0]        mem [fifo_depth];
  logic [$clog2(fifo_depth)-1:0] wr_ptr;
  logic [$clog2(fifo_depth)-1:0] rd_ptr;
  logic [$clog2(fifo_depth):0]   count;
  logic                          full;
  logic                          do_push;
  logic                          do_pop;

  assign empty   = (count == '0);
  assign full    = (count == fifo_depth);
  assign do_push = push && !full;
  assign do_pop  = pop && !empty;
  assign dout    = mem[rd_ptr];  // head word, fall through

  always_ff @(posedge vga_clk) begin
    if (do_push) mem[wr_ptr] <= din;
  end

  always_ff @(posedge vga_clk) begin
    if (mem_reset || flush) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) wr_ptr <= wr_ptr + 1'b1;
      if (do_pop) rd_ptr <= rd_ptr + 1'b1;
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  no_overrun: assert property (@(posedge vga_clk) disable iff (mem_reset || flush)
    !(push && full) && !(pop && empty));

endmodule

// ==== pixel_scanout.sv ====
`timescale 1ns/1ps

module pixel_scanout
  import vga_pkg::*;
(
  input  logic                 vga_clk,
  input  logic                 mem_reset,
  input  sync_t                sync_pre,
  input  logic                 de_pre,
  input  logic [word_bits-1:0] fifo_dout,
  input  logic                 fifo_empty,
  output logic                 fifo_pop,
  output sync_t                vga_sync,
  output pix_t                 vga_rgb
);

  logic [$clog2(word_bits)-1:0] bit_idx;
  logic                         pix_on;

  // one bit per pixel, lsb first
  assign pix_on   = de_pre && !fifo_empty && fifo_dout[bit_idx];
  assign fifo_pop = de_pre && !fifo_empty && (&bit_idx);  // last bit of the word

  always_ff @(posedge vga_clk) begin
    if (mem_reset) begin
      bit_idx  <= '0;
      vga_sync <= sync_reset;
      vga_rgb  <= '0;
    end else begin
      vga_sync <= sync_pre;
      if (pix_on) begin
        vga_rgb <= '1;
      end else begin
        vga_rgb <= '0;
      end
      if (de_pre) begin
        bit_idx <= bit_idx + 1'b1;
      end else begin
        bit_idx <= '0;  // back to bit 0 for the next line
      end
    end
  end

  // the fetch must land before the line is shown
  line_ready: assert property (@(posedge vga_clk) disable iff (mem_reset)
    $rose(de_pre) |-> !fifo_empty);

endmodule

// ==== vga_core.sv ====
`timescale 1ns/1ps

module vga_core
  import vga_pkg::*;
(
  input  logic    vga_clk,
  input  logic    mem_reset,
  output mem_ar_t mem_ar,
  output logic    mem_arvalid,
  input  logic    mem_arready,
  input  mem_r_t  mem_r,
  input  logic    mem_rvalid,
  output logic    mem_rready,
  output sync_t   vga_sync,
  output pix_t    vga_rgb
);

  line_req_t            line_req;
  sync_t                sync_pre;
  logic                 de_pre;
  logic                 fifo_flush;
  logic                 fifo_push;
  logic [word_bits-1:0] fifo_din;
  logic [word_bits-1:0] fifo_dout;
  logic                 fifo_empty;
  logic                 fifo_pop;

  vga_timing u_timing (
    .vga_clk   (vga_clk),
    .mem_reset (mem_reset),
    .sync_pre  (sync_pre),
    .de_pre    (de_pre),
    .line_req  (line_req)
  );

  line_fetch u_fetch (
    .vga_clk     (vga_clk),
    .mem_reset   (mem_reset),
    .line_req    (line_req),
    .mem_ar      (mem_ar),
    .mem_arvalid (mem_arvalid),
    .mem_arready (mem_arready),
    .mem_r       (mem_r),
    .mem_rvalid  (mem_rvalid),
    .mem_rready  (mem_rready),
    .fifo_flush  (fifo_flush),
    .fifo_push   (fifo_push),
    .fifo_din    (fifo_din)
  );

  pixel_fifo u_fifo (
    .vga_clk   (vga_clk),
    .mem_reset (mem_reset),
    .flush     (fifo_flush),
    .push      (fifo_push),
    .din       (fifo_din),
    .pop       (fifo_pop),
    .dout      (fifo_dout),
    .empty     (fifo_empty)
  );

  pixel_scanout u_scanout (
    .vga_clk    (vga_clk),
    .mem_reset  (mem_reset),
    .sync_pre   (sync_pre),
    .de_pre     (de_pre),
    .fifo_dout  (fifo_dout),
    .fifo_empty (fifo_empty),
    .fifo_pop   (fifo_pop),
    .vga_sync   (vga_sync),
    .vga_rgb    (vga_rgb)
  );

endmodule

// ==== tb_clock_gen.sv ====
`timescale 1ns/1ps

module tb_clock_gen (
  output logic vga_clk,
  output logic mem_reset
);

  initial begin
    vga_clk = 1'b0;
    forever #20 vga_clk = ~vga_clk;  // 25 MHz
  end

  // 8 rising edges in reset, released on a falling edge
  initial begin
    mem_reset = 1'b1;
    repeat (8) @(posedge vga_clk);
    @(negedge vga_clk);
    mem_reset = 1'b0;
  end

endmodule

// ==== tb_vga_core.sv ====
`timescale 1ns/1ps

module tb_vga_core
  import vga_pkg::*;
();

  logic        vga_clk;
  logic        mem_reset;
  mem_ar_t     mem_ar;
  logic        mem_arvalid;
  logic        mem_arready;
  mem_r_t      mem_r;
  logic        mem_rvalid;
  logic        mem_rready;
  sync_t       vga_sync;
  pix_t        vga_rgb;

  logic [31:0] rng;
  int          stall_left;
  logic        stall_armed;
  int          cyc;
  logic [31:0] beat_addr[$];
  int          beat_cyc[$];
  logic        beat_last[$];
  int          fetch_line;   // active line of the next burst
  int          words_done;
  logic [31:0] exp_addr;
  int          exp_len;
  logic        split_seen;
  int          lines_seen;
  logic        hsync_q;
  logic [11:0] ref_h;
  logic [11:0] ref_v;
  sync_t       sync_s1;
  sync_t       exp_sync;
  pix_t        pix_s1;
  pix_t        exp_rgb;

  tb_clock_gen i_clk_gen (.vga_clk, .mem_reset);

  vga_core i_dut (.*);

  function automatic logic [31:0] lcg_step(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  function automatic sync_t sync_at(input logic [11:0] h, input logic [11:0] v);
    sync_t s;
    s.hsync  = !(h >= 12'd704);  // last 96 counts
    s.hblank = !(h >= 12'd48 && h <= 12'd687);
    s.vsync  = !(v >= 12'd523);
    s.vblank = !(v >= 12'd32 && v <= 12'd511);
    return s;
  endfunction

  function automatic pix_t pixel_at(input logic [11:0] h, input logic [11:0] v);
    int           x;
    int           y;
    logic [31:0]  addr;
    logic [127:0] word;
    if (h < 12'd48 || h > 12'd687 || v < 12'd32 || v > 12'd511) return '0;
    x    = int'(h) - 48;
    y    = int'(v) - 32;
    addr = 32'(y * 80 + (x / 128) * 16);
    word = {4{addr}};
    return word[x % 128] ? 24'hffffff : 24'h000000;
  endfunction

  task automatic halt_on_failure();
    $display("Some tests failed");
    $fatal(1, "stopped at the first failure");
  endtask

  task automatic report_value(input string name, input logic [127:0] got,
                              input logic [127:0] want);
    $display("Error at %0t ns: %s is %0h, expected %0h", $time, name, got, want);
    halt_on_failure();
  endtask

  // expected burst, then its beats queued back to back
  task automatic queue_burst();
    int room;
    int slot;
    exp_addr = 32'(fetch_line * 80 + words_done * 16);
    room     = (4096 - int'(exp_addr % 4096)) / 16;
    exp_len  = (5 - words_done < room) ? 5 - words_done : room;
    if (exp_addr == 32'd4080) split_seen = 1'b1;  // active line 51
    slot = cyc + 2;
    if (beat_cyc.size() > 0 && beat_cyc[$] >= slot) slot = beat_cyc[$] + 1;
    for (int i = 0; i <= int'(mem_ar.len); i++) begin
      beat_addr.push_back(32'(mem_ar.addr) + 32'(i * 16));
      beat_cyc.push_back(slot + i);
      beat_last.push_back(i == int'(mem_ar.len));
    end
    words_done = words_done + int'(mem_ar.len) + 1;
    if (words_done >= 5) begin
      words_done = 0;
      fetch_line = (fetch_line + 1) % 480;
    end
  endtask

  // ------------------------------
  // memory model
  // ------------------------------
  initial begin
    mem_arready = 1'b0;
    mem_rvalid  = 1'b0;
    mem_r       = '0;
    rng         = 32'd79;
    stall_left  = 0;
    stall_armed = 1'b0;
    cyc         = 0;
    fetch_line  = 0;
    words_done  = 0;
    exp_addr    = '0;
    exp_len     = 0;
    split_seen  = 1'b0;
    forever begin
      @(negedge vga_clk);
      cyc = cyc + 1;
      if (beat_addr.size() > 0 && beat_cyc[0] <= cyc) begin
        mem_rvalid = 1'b1;
        mem_r.data = {4{beat_addr.pop_front()}};
        mem_r.last = beat_last.pop_front();
        void'(beat_cyc.pop_front());
      end else begin
        mem_rvalid = 1'b0;
      end
      if (mem_reset || !mem_arvalid) begin
        mem_arready = 1'b0;
      end else begin
        if (!stall_armed) begin
          rng         = lcg_step(rng);
          stall_left  = int'(rng[17:16]);  // 0 to 3 cycles
          stall_armed = 1'b1;
        end
        if (stall_left > 0) begin
          mem_arready = 1'b0;
          stall_left  = stall_left - 1;
        end else begin
          mem_arready = 1'b1;
          stall_armed = 1'b0;
          queue_burst();
        end
      end
    end
  end

  // reference position, two stages behind the count like the outputs
  always_ff @(posedge vga_clk) begin
    if (mem_reset) begin
      ref_h    <= '0;
      ref_v    <= '0;
      sync_s1  <= 4'b1111;
      exp_sync <= 4'b1111;
      pix_s1   <= '0;
      exp_rgb  <= '0;
    end else begin
      ref_h <= (ref_h == 12'd799) ? 12'd0 : ref_h + 12'd1;
      if (ref_h == 12'd799) ref_v <= (ref_v == 12'd524) ? 12'd0 : ref_v + 12'd1;
      sync_s1  <= sync_at(ref_h, ref_v);
      pix_s1   <= pixel_at(ref_h, ref_v);
      exp_sync <= sync_s1;
      exp_rgb  <= pix_s1;
    end
  end

  always @(negedge vga_clk) begin
    if (mem_reset) begin
      lines_seen = 0;
      hsync_q    = 1'b1;
    end else begin
      if (hsync_q && !vga_sync.hsync) lines_seen = lines_seen + 1;
      hsync_q = vga_sync.hsync;
    end
  end

  // ------------------------------
  // checks
  // ------------------------------
  reset_state: assert property (@(posedge vga_clk)
    mem_reset |=> !mem_arvalid && vga_rgb == '0 && vga_sync == 4'b1111)
    else begin
      $display("outputs were not in their reset state at %0t ns", $time);
      halt_on_failure();
    end

  sync_match: assert property (@(posedge vga_clk) disable iff (mem_reset)
    vga_sync == exp_sync)
    else report_value("vga_sync", $sampled(vga_sync), $sampled(exp_sync));

  rgb_match: assert property (@(posedge vga_clk) disable iff (mem_reset)
    vga_rgb == exp_rgb)
    else report_value("vga_rgb", $sampled(vga_rgb), $sampled(exp_rgb));

  rready_high: assert property (@(posedge vga_clk)
    mem_rready)
    else report_value("mem_rready", $sampled(mem_rready), 128'd1);

  ar_held: assert property (@(posedge vga_clk) disable iff (mem_reset)
    mem_arvalid && !mem_arready |=> mem_arvalid && $stable(mem_ar))
    else begin
      $display("mem_ar changed or dropped while waiting at %0t ns", $time);
      halt_on_failure();
    end

  ar_addr_match: assert property (@(posedge vga_clk) disable iff (mem_reset)
    mem_arvalid && mem_arready |-> 32'(mem_ar.addr) == exp_addr)
    else report_value("mem_ar.addr", $sampled(mem_ar.addr), $sampled(exp_addr));

  ar_len_match: assert property (@(posedge vga_clk) disable iff (mem_reset)
    mem_arvalid && mem_arready |-> int'(mem_ar.len) + 1 == exp_len)
    else report_value("mem_ar.len", $sampled(mem_ar.len), 128'($sampled(exp_len) - 1));

  // 16-byte beats, incrementing
  ar_size_match: assert property (@(posedge vga_clk) disable iff (mem_reset)
    mem_arvalid |-> mem_ar.size == 3'b100)
    else report_value("mem_ar.size", $sampled(mem_ar.size), 128'd4);

  ar_burst_match: assert property (@(posedge vga_clk) disable iff (mem_reset)
    mem_arvalid |-> mem_ar.burst == 2'b01)
    else report_value("mem_ar.burst", $sampled(mem_ar.burst), 128'd1);

  ar_page: assert property (@(posedge vga_clk) disable iff (mem_reset)
    mem_arvalid |-> int'(mem_ar.addr[11:0]) + (int'(mem_ar.len) + 1) * 16 <= 4096)
    else begin
      $display("burst at %0t ns crosses a 4 KB page", $time);
      halt_on_failure();
    end

  // one frame plus 40 lines
  initial begin
    int waited;
    waited = 0;
    while (mem_reset !== 1'b0 && waited < 100) begin
      @(posedge vga_clk);
      waited = waited + 1;
    end
    if (mem_reset !== 1'b0) begin
      $display("reset was never released");
      halt_on_failure();
    end else begin
      waited = 0;
      while (lines_seen < 565 && waited < 565 * 800 + 4000) begin
        @(posedge vga_clk);
        waited = waited + 1;
      end
      if (lines_seen < 565) begin
        $display("timed out with %0d of 565 lines seen", lines_seen);
        halt_on_failure();
      end else if (!split_seen) begin
        $display("the page split at active line 51 was never reached");
        halt_on_failure();
      end else begin
        $display("All tests passed");
        $finish;
      end
    end
  end

endmodule

// ==== files.f ====
vga_pkg.sv
vga_timing.sv
line_fetch.sv
pixel_fifo.sv
pixel_scanout.sv
vga_core.sv
tb_clock_gen.sv
tb_vga_core.sv
